/* tscCpu.f */
tscPkg.sv
aluUnit.sv
regFile.sv
controlUnit.sv
datapath.sv
tscCpu.sv
tscCpu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tscCpu_tb
FILELIST = tscCpu.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides the result, the simulator status alone does not
run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tscCpu_input.txt */
// one 16-bit hex word per entry: 00-3f program and data image, 40 store count,
// 41 onward expected store address/value pairs, then the expected pc at halt
@00
6112 5534 43F0 F780 8230 FD81 8231 F782
8232 F783 8233 F484 8234 F485 8235 F486
// shr, loads, then the four branch pairs with poison stores to 3d
8236 FC87 8237 713E 733F 8138 0501 1501
813D 1701 0701 813D 2401 2C01 813D 3C01
// jal, jrl, jpr, jmp and hlt at 2f
3401 813D A024 813D 8239 4328 FC1A 813D
823A 432C FC19 813D 902E 813D 833B F01D
// store area 30-3b, load data at 3e and 3f
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 8001 0005
@40
000C
0030 1224
0031 EDBC
0032 1230
0033 FFF4
0034 EDCB
0035 EDCC
0036 2468
0037 FFF8
0038 8001
0039 0023
003A 0027
003B 002C
002F

/* tscCpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tscCpu_tb;

    localparam int ws            = tscPkg::wordSize;
    localparam int imageWords    = 64;
    localparam int cyclesPerWord = 400;
    localparam int waitFactor    = 4;
    localparam int timeoutCycles = imageWords * cyclesPerWord * waitFactor;
    localparam int countIdx      = 64;
    localparam int pairBase      = 65;
    localparam int driveDelay    = 2;
    localparam int haltSettle    = 20;

    logic          clk;
    logic          rstN;
    logic          memRead;
    logic          memWrite;
    logic [ws-1:0] memAddr;
    logic [ws-1:0] memWdata;
    logic [ws-1:0] memRdata;
    logic          memAck;
    logic          halted;

    logic [ws-1:0] inputWords [0:127];
    logic [ws-1:0] mem [0:imageWords-1];
    int            seed;
    int            expectedStores;
    int            storeIdx;
    logic [ws-1:0] finalPc;
    logic [ws-1:0] lastAccessAddr;

    tscCpu #(
        .resetPc (16'h0000)
    ) tscCpu_i (
        .clk      (clk),
        .rstN     (rstN),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .memAck   (memAck),
        .halted   (halted)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    // compare one store with the next expected pair from the data file
    task automatic checkStore(input logic [ws-1:0] addr, input logic [ws-1:0] data);
        logic [ws-1:0] expAddr;
        logic [ws-1:0] expData;
        assert (storeIdx < expectedStores)
            else abortRun($sformatf("unexpected extra store of %h to address %h", data, addr));
        expAddr = inputWords[pairBase + 2 * storeIdx];
        expData = inputWords[pairBase + 2 * storeIdx + 1];
        assert (addr == expAddr)
            else abortRun($sformatf("Fail storeAddr: got %h expected %h", addr, expAddr));
        assert (data == expData)
            else abortRun($sformatf("Fail storeData: got %h expected %h", data, expData));
        storeIdx++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstN           = 1'b0;
        memAck         = 1'b0;
        memRdata       = '0;
        seed           = 59;
        storeIdx       = 0;
        lastAccessAddr = '0;
        $readmemh("tscCpu_input.txt", inputWords);
        assert (!$isunknown(inputWords[countIdx]))
            else abortRun("data file tscCpu_input.txt is missing or incomplete");
        for (int i = 0; i < imageWords; i++) begin
            mem[i] = inputWords[i];
        end
        expectedStores = int'(inputWords[countIdx]);
        finalPc        = inputWords[pairBase + 2 * expectedStores];
        repeat (3) @(posedge clk);
        #driveDelay;
        assert (!memRead && !memWrite && !halted)
            else abortRun("memory request or halted active during reset");
        rstN = 1'b1;
        wait (halted === 1'b1);
        // keep watching the port so a late request is still caught
        repeat (haltSettle) @(posedge clk);
        assert (halted)
            else abortRun("halted dropped after the core stopped");
        assert (storeIdx == expectedStores)
            else abortRun($sformatf("Fail storeCount: got %h expected %h",
                                    storeIdx, expectedStores));
        assert (lastAccessAddr == finalPc)
            else abortRun($sformatf("Fail haltPc: got %h expected %h", lastAccessAddr, finalPc));
        $display("** PASS **");
        $finish;
    end

    // memory model, 0 to 3 wait cycles per access
    initial begin : memoryModel
        logic          pending;
        logic          pendingWrite;
        logic [ws-1:0] pendingAddr;
        logic [ws-1:0] pendingData;
        int            waitLeft;
        pending      = 1'b0;
        pendingWrite = 1'b0;
        pendingAddr  = '0;
        pendingData  = '0;
        waitLeft     = 0;
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            #driveDelay;
            if (memAck) begin
                // acknowledge was taken at this edge
                memAck = 1'b0;
                assert (!memRead && !memWrite)
                    else abortRun("request still active in the cycle after acknowledge");
            end else if (memRead || memWrite) begin
                assert (!(memRead && memWrite))
                    else abortRun("read and write requested at the same time");
                assert (!halted)
                    else abortRun("memory request after the core halted");
                assert (memAddr < imageWords)
                    else abortRun($sformatf("memory address %h is outside the model", memAddr));
                if (!pending) begin
                    pending      = 1'b1;
                    pendingWrite = memWrite;
                    pendingAddr  = memAddr;
                    pendingData  = memWdata;
                    waitLeft     = $random(seed) & 3;
                end else begin
                    assert (memWrite == pendingWrite)
                        else abortRun("request switched between read and write while waiting");
                    assert (memAddr == pendingAddr)
                        else abortRun($sformatf("Fail memAddr: got %h expected %h",
                                                memAddr, pendingAddr));
                    assert (!pendingWrite || memWdata == pendingData)
                        else abortRun($sformatf("Fail memWdata: got %h expected %h",
                                                memWdata, pendingData));
                end
                if (waitLeft == 0) begin
                    pending        = 1'b0;
                    memAck         = 1'b1;
                    lastAccessAddr = memAddr;
                    if (memWrite) begin
                        mem[memAddr[5:0]] = memWdata;
                        checkStore(memAddr, memWdata);
                    end else begin
                        memRdata = mem[memAddr[5:0]];
                    end
                end else begin
                    waitLeft--;
                end
            end else begin
                assert (!pending)
                    else abortRun("request dropped before acknowledge");
            end
        end
    end

    initial begin : watchdog
        repeat (timeoutCycles) @(posedge clk);
        abortRun($sformatf("program never halted within %0d cycles", timeoutCycles));
    end

endmodule

`default_nettype wire

/* tscCpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tscCpu #(
    parameter logic [tscPkg::wordSize-1:0] resetPc = '0
) (
    input  logic                        clk,
    input  logic                        rstN,
    output logic                        memRead,
    output logic                        memWrite,
    output logic [tscPkg::wordSize-1:0] memAddr,
    output logic [tscPkg::wordSize-1:0] memWdata,
    input  logic [tscPkg::wordSize-1:0] memRdata,
    input  logic                        memAck,
    output logic                        halted
);

    tscPkg::ctrlS  ctrl;
    tscPkg::instrU instr;

    controlUnit controlUnit_i (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .memAck (memAck),
        .ctrl   (ctrl),
        .halted (halted)
    );

    datapath #(
        .resetPc (resetPc)
    ) datapath_i (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .memAck   (memAck),
        .instr    (instr),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath #(
    parameter logic [tscPkg::wordSize-1:0] resetPc = '0
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  tscPkg::ctrlS                ctrl,
    input  logic [tscPkg::wordSize-1:0] memRdata,
    input  logic                        memAck,
    output tscPkg::instrU               instr,
    output logic                        memRead,
    output logic                        memWrite,
    output logic [tscPkg::wordSize-1:0] memAddr,
    output logic [tscPkg::wordSize-1:0] memWdata
);

    localparam int ws = tscPkg::wordSize;

    logic [ws-1:0] pc;
    tscPkg::instrU ir;
    logic [ws-1:0] aluOut;
    logic [ws-1:0] mdr;

    logic [ws-1:0] rdData1;
    logic [ws-1:0] rdData2;
    logic [1:0]    wrAddr;
    logic [ws-1:0] wbData;

    logic [ws-1:0] immExt;
    logic [ws-1:0] aluB;
    logic [ws-1:0] aluResult;

    logic [ws-1:0] pcInc;
    logic [ws-1:0] branchTarget;
    logic [ws-1:0] jumpTarget;
    logic          branchTaken;
    logic [ws-1:0] pcNext;

    assign instr = ir;

    // link writes go to register 2
    assign wrAddr = ctrl.link ? 2'd2 : (ctrl.regDst ? ir.r.rd : ir.r.rt);

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddr1 (ir.r.rs),
        .rdAddr2 (ir.r.rt),
        .wrAddr  (wrAddr),
        .wrData  (wbData),
        .wrEn    (ctrl.regWrite),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    assign immExt = {{(ws - 8){ir.i.imm[7]}}, ir.i.imm};
    assign aluB   = ctrl.aluSrc ? immExt : rdData2;

    // overflow is reported by the ALU but has no consumer in this core
    aluUnit aluUnit_i (
        .a        (rdData1),
        .b        (aluB),
        .op       (ctrl.aluOp),
        .result   (aluResult),
        .overflow ()
    );

    // branch offsets are relative to the following instruction
    assign pcInc        = pc + 1'b1;
    assign branchTarget = pcInc + immExt;
    assign jumpTarget   = {pc[ws-1 -: 4], ir.j.target};

    always_comb begin
        case (ctrl.branchKind)
            tscPkg::brNe: branchTaken = (rdData1 != rdData2);
            tscPkg::brEq: branchTaken = (rdData1 == rdData2);
            tscPkg::brGz: branchTaken = ($signed(rdData1) > 0);
            default:      branchTaken = ($signed(rdData1) < 0);
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            tscPkg::pcSelBranch: pcNext = branchTaken ? branchTarget : pcInc;
            tscPkg::pcSelJump:   pcNext = jumpTarget;
            tscPkg::pcSelReg:    pcNext = rdData1;
            default:             pcNext = pcInc;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            tscPkg::wbSelMem: wbData = mdr;
            // pc still holds the jump address here
            tscPkg::wbSelPc:  wbData = pcInc;
            tscPkg::wbSelLhi: wbData = {ir.i.imm, 8'h00};
            default:          wbData = aluOut;
        endcase
    end

    // pc stays on the HLT word once halted
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (ctrl.writeback && !ctrl.halt) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
        end else if (ctrl.fetch && memAck) begin
            ir <= tscPkg::instrU'(memRdata);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.exec) begin
            aluOut <= aluResult;
        end
        if (ctrl.memAccess && memAck) begin
            mdr <= memRdata;
        end
    end

    assign memRead  = ctrl.memRead;
    assign memWrite = ctrl.memWrite;
    assign memAddr  = ctrl.fetch ? pc : aluOut;
    // store data is rt, untouched between execute and memory
    assign memWdata = rdData2;

    addrStable: assert property (@(posedge clk) disable iff (!rstN)
        (memRead || memWrite) && !memAck |=> (memRead || memWrite) && $stable(memAddr));

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic          clk,
    input  logic          rstN,
    input  tscPkg::instrU instr,
    input  logic          memAck,
    output tscPkg::ctrlS  ctrl,
    output logic          halted
);

    tscPkg::phaseE phase;
    tscPkg::phaseE phaseNext;
    tscPkg::ctrlS  dec;
    logic          isMem;

    // static decode of the instruction register
    always_comb begin
        dec            = '0;
        dec.branchKind = instr.r.opcode[1:0];
        case (instr.r.opcode)
            tscPkg::opBne, tscPkg::opBeq, tscPkg::opBgz, tscPkg::opBlz: begin
                dec.pcSel = tscPkg::pcSelBranch;
            end
            tscPkg::opAdi: begin
                dec.aluSrc   = 1'b1;
                dec.regWrite = 1'b1;
            end
            tscPkg::opOri: begin
                dec.aluSrc   = 1'b1;
                dec.aluOp    = tscPkg::aluOr;
                dec.regWrite = 1'b1;
            end
            tscPkg::opLhi: begin
                dec.regWrite = 1'b1;
                dec.wbSel    = tscPkg::wbSelLhi;
            end
            tscPkg::opLwd: begin
                dec.aluSrc   = 1'b1;
                dec.memRead  = 1'b1;
                dec.regWrite = 1'b1;
                dec.wbSel    = tscPkg::wbSelMem;
            end
            tscPkg::opSwd: begin
                dec.aluSrc   = 1'b1;
                dec.memWrite = 1'b1;
            end
            tscPkg::opJmp: dec.pcSel = tscPkg::pcSelJump;
            tscPkg::opJal: begin
                dec.pcSel    = tscPkg::pcSelJump;
                dec.link     = 1'b1;
                dec.regWrite = 1'b1;
                dec.wbSel    = tscPkg::wbSelPc;
            end
            tscPkg::opRtype: begin
                dec.regDst = 1'b1;
                case (instr.r.func)
                    tscPkg::fnAdd: dec.aluOp = tscPkg::aluAdd;
                    tscPkg::fnSub: dec.aluOp = tscPkg::aluSub;
                    tscPkg::fnAnd: dec.aluOp = tscPkg::aluAnd;
                    tscPkg::fnOrr: dec.aluOp = tscPkg::aluOr;
                    tscPkg::fnNot: dec.aluOp = tscPkg::aluNot;
                    tscPkg::fnTcp: dec.aluOp = tscPkg::aluTcp;
                    tscPkg::fnShl: dec.aluOp = tscPkg::aluShl;
                    tscPkg::fnShr: dec.aluOp = tscPkg::aluShr;
                    default: ;
                endcase
                // only the eight ALU functions write rd
                dec.regWrite = (instr.r.func <= tscPkg::fnShr);
                if (instr.r.func == tscPkg::fnJpr || instr.r.func == tscPkg::fnJrl) begin
                    dec.pcSel = tscPkg::pcSelReg;
                end
                if (instr.r.func == tscPkg::fnJrl) begin
                    dec.link     = 1'b1;
                    dec.regWrite = 1'b1;
                    dec.wbSel    = tscPkg::wbSelPc;
                end
                dec.halt = (instr.r.func == tscPkg::fnHlt);
            end
            default: ;
        endcase
    end

    assign isMem = dec.memRead || dec.memWrite;

    // idle keeps the port quiet during reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= tscPkg::phIdle;
        end else begin
            phase <= phaseNext;
        end
    end

    always_comb begin
        case (phase)
            tscPkg::phIdle:      phaseNext = tscPkg::phFetch;
            tscPkg::phFetch:     phaseNext = memAck ? tscPkg::phDecode : tscPkg::phFetch;
            tscPkg::phDecode:    phaseNext = tscPkg::phExec;
            tscPkg::phExec:      phaseNext = isMem ? tscPkg::phMem : tscPkg::phWriteback;
            tscPkg::phMem:       phaseNext = memAck ? tscPkg::phWriteback : tscPkg::phMem;
            tscPkg::phWriteback: phaseNext = dec.halt ? tscPkg::phHalted : tscPkg::phFetch;
            tscPkg::phHalted:    phaseNext = tscPkg::phHalted;
            default:             phaseNext = tscPkg::phFetch;
        endcase
    end

    // phase flags gate the requests and the register write
    always_comb begin
        ctrl           = dec;
        ctrl.fetch     = (phase == tscPkg::phFetch);
        ctrl.exec      = (phase == tscPkg::phExec);
        ctrl.memAccess = (phase == tscPkg::phMem);
        ctrl.writeback = (phase == tscPkg::phWriteback);
        ctrl.memRead   = ctrl.fetch || (ctrl.memAccess && dec.memRead);
        ctrl.memWrite  = ctrl.memAccess && dec.memWrite;
        ctrl.regWrite  = ctrl.writeback && dec.regWrite;
    end

    assign halted = (phase == tscPkg::phHalted);

    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite));

    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        phase == tscPkg::phHalted |=> phase == tscPkg::phHalted);

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [1:0]                  rdAddr1,
    input  logic [1:0]                  rdAddr2,
    input  logic [1:0]                  wrAddr,
    input  logic [tscPkg::wordSize-1:0] wrData,
    input  logic                        wrEn,
    output logic [tscPkg::wordSize-1:0] rdData1,
    output logic [tscPkg::wordSize-1:0] rdData2
);

    logic [3:0][tscPkg::wordSize-1:0] regs;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // combinational reads, a write shows up after the edge
    assign rdData1 = regs[rdAddr1];
    assign rdData2 = regs[rdAddr2];

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  logic [tscPkg::wordSize-1:0] a,
    input  logic [tscPkg::wordSize-1:0] b,
    input  tscPkg::aluOpE               op,
    output logic [tscPkg::wordSize-1:0] result,
    output logic                        overflow
);

    logic [tscPkg::wordSize-1:0] sum;
    logic [tscPkg::wordSize-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        result   = sum;
        overflow = 1'b0;
        case (op)
            tscPkg::aluAdd: begin
                result = sum;
                // operands agree in sign but the sum does not
                overflow = (a[tscPkg::wordSize-1] == b[tscPkg::wordSize-1]) &&
                           (sum[tscPkg::wordSize-1] != a[tscPkg::wordSize-1]);
            end
            tscPkg::aluSub: begin
                result = diff;
                overflow = (a[tscPkg::wordSize-1] != b[tscPkg::wordSize-1]) &&
                           (diff[tscPkg::wordSize-1] != a[tscPkg::wordSize-1]);
            end
            tscPkg::aluAnd: result = a & b;
            tscPkg::aluOr:  result = a | b;
            tscPkg::aluNot: result = ~a;
            tscPkg::aluTcp: result = ~a + 1'b1;
            tscPkg::aluShl: result = {a[tscPkg::wordSize-2:0], 1'b0};
            // arithmetic shift keeps the sign bit
            tscPkg::aluShr: result = {a[tscPkg::wordSize-1], a[tscPkg::wordSize-1:1]};
            default: begin
                result   = sum;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* tscPkg.sv */
`default_nettype none

package tscPkg;

    localparam int wordSize = 16;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRtype = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOrr = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnHlt = 6'd29
    } funcE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr
    } aluOpE;

    // next pc sources
    localparam logic [1:0] pcSelInc    = 2'd0;
    localparam logic [1:0] pcSelBranch = 2'd1;
    localparam logic [1:0] pcSelJump   = 2'd2;
    localparam logic [1:0] pcSelReg    = 2'd3;

    // writeback sources
    localparam logic [1:0] wbSelAlu = 2'd0;
    localparam logic [1:0] wbSelMem = 2'd1;
    localparam logic [1:0] wbSelPc  = 2'd2;
    localparam logic [1:0] wbSelLhi = 2'd3;

    // branch conditions, same encoding as the low opcode bits
    localparam logic [1:0] brNe = 2'd0;
    localparam logic [1:0] brEq = 2'd1;
    localparam logic [1:0] brGz = 2'd2;
    localparam logic [1:0] brLz = 2'd3;

    typedef struct packed {
        opcodeE     opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        funcE       func;
    } rTypeS;

    typedef struct packed {
        opcodeE     opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iTypeS;

    typedef struct packed {
        opcodeE      opcode;
        logic [11:0] target;
    } jTypeS;

    typedef union packed {
        rTypeS r;
        iTypeS i;
        jTypeS j;
    } instrU;

    typedef struct packed {
        logic       fetch;
        logic       exec;
        logic       memAccess;
        logic       writeback;
        logic       memRead;
        logic       memWrite;
        logic       regWrite;
        logic       regDst;
        logic       aluSrc;
        aluOpE      aluOp;
        logic [1:0] pcSel;
        logic [1:0] wbSel;
        logic [1:0] branchKind;
        logic       link;
        logic       halt;
    } ctrlS;

    typedef enum logic [2:0] {
        phIdle,
        phFetch,
        phDecode,
        phExec,
        phMem,
        phWriteback,
        phHalted
    } phaseE;

endpackage

`default_nettype wire
